// File: common/udp_tx_pkg.sv
package udp_tx_pkg;

	// ethernet header
	localparam logic [47:0] eth_dst_mac = 48'hffff_ffff_ffff; // broadcast
	localparam logic [47:0] eth_src_mac = 48'hdead_beef_0123;
	localparam logic [15:0] eth_type_ipv4 = 16'h0800;

	// ipv4 header, fixed part
	localparam logic [7:0] ip_ver_ihl = 8'h45; // v4, 5 words, no options
	localparam logic [15:0] ip_ident = 16'h0000;
	localparam logic [15:0] ip_flags_df = 16'h4000; // don't fragment, offset 0
	localparam logic [7:0] ip_ttl_val = 8'd64;
	localparam logic [7:0] ip_proto_udp = 8'h11;
	localparam logic [31:0] ip_src_addr = 32'hc0a8_0140; // 192.168.1.64
	localparam logic [31:0] ip_dst_addr = 32'hc0a8_0102; // 192.168.1.2

	// byte counts of each header layer
	localparam int eth_hdr_bytes = 14;
	localparam int ip_hdr_bytes = 20;
	localparam int udp_hdr_bytes = 8;
	localparam int proto_bytes = 3; // aux low byte + start address

	// counter starts at 1 for the first header byte
	localparam int first_payload_count =
		eth_hdr_bytes + ip_hdr_bytes + udp_hdr_bytes + proto_bytes + 1;

	// idle advances after the last payload byte
	localparam int gap_count = 22;

	// builder sequencing
	typedef enum logic [1:0] {
		st_idle,    // waiting for start
		st_header,  // counter 0 .. last header byte
		st_payload, // streaming video ram bytes
		st_gap      // inter-frame gap, data_valid low
	} builder_state_e;

endpackage

// File: common/vram_if.sv
`timescale 1ns/100ps

// one byte-wide ram port, shared by a requester and the memory side
interface vram_if #(
	parameter int vram_addr_width = 16
) ();

	logic req; // qualified by gnt
	logic we;
	logic [vram_addr_width-1:0] addr;
	logic [7:0] wdata;
	logic gnt; // combinational, same cycle as req
	logic [7:0] rdata; // valid the cycle after a granted read

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input gnt,
		input rdata
	);

	modport memory (
		input req,
		input we,
		input addr,
		input wdata,
		output gnt,
		output rdata
	);

endinterface

// File: vram/vram_store.sv
`timescale 1ns/100ps

module vram_store #(
	parameter int vram_addr_width = 16
) (
	input logic clk,
	vram_if.memory mem
);

	localparam int depth = 2 ** vram_addr_width;

	logic [7:0] ram [depth];
	logic take;

	// single port, always ready
	assign mem.gnt = mem.req;
	assign take = mem.req && mem.gnt;

	always_ff @(posedge clk) begin
		if (take && mem.we) begin
			ram[mem.addr] <= mem.wdata;
		end
		// rdata only moves on a granted read, holds otherwise
		if (take && !mem.we) begin
			mem.rdata <= ram[mem.addr];
		end
	end

	// an X address would corrupt or read an unknown cell
	assert property (@(posedge clk) mem.req |-> !$isunknown(mem.addr))
		else $error("vram_store: address unknown while req is high");

endmodule

// File: vram/vram_arbiter.sv
`timescale 1ns/100ps

module vram_arbiter (
	input logic clk,
	input logic arst_n,
	vram_if.memory rd, // frame builder, top priority
	vram_if.memory wr, // pixel loader
	vram_if.requester mem
);

	logic sel_rd;

	// builder wins whenever it asks, so its stream never stalls
	assign sel_rd = rd.req;

	assign mem.req = rd.req || wr.req;
	assign mem.we = sel_rd ? rd.we : wr.we;
	assign mem.addr = sel_rd ? rd.addr : wr.addr;
	assign mem.wdata = sel_rd ? rd.wdata : wr.wdata;

	assign rd.gnt = rd.req && mem.gnt;
	assign wr.gnt = wr.req && !rd.req && mem.gnt; // only in read-free cycles

	// read data fans out to both, loader ignores it
	assign rd.rdata = mem.rdata;
	assign wr.rdata = mem.rdata;

	assert property (@(posedge clk) disable iff (!arst_n) !(rd.gnt && wr.gnt))
		else $error("vram_arbiter: both sides granted in one cycle");

	// a waiting write must stay posted until it gets through
	assert property (@(posedge clk) disable iff (!arst_n)
		wr.req && !wr.gnt |=> wr.req)
		else $error("vram_arbiter: write request withdrawn before grant");

endmodule

// File: source/pixel_loader.sv
`timescale 1ns/100ps

module pixel_loader #(
	parameter int fifo_depth = 4,
	parameter int vram_addr_width = 16
) (
	input logic clk,
	input logic arst_n,
	input logic pix_wr,
	input logic [vram_addr_width-1:0] pix_addr,
	input logic [7:0] pix_data,
	output logic pix_full,
	vram_if.requester wr
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);
	localparam logic [ptr_w-1:0] last_slot = ptr_w'(fifo_depth - 1);

	logic [vram_addr_width-1:0] addr_mem [fifo_depth];
	logic [7:0] data_mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic push;
	logic pop;

	assign push = pix_wr && !pix_full; // writes while full are dropped
	assign pop = wr.req && wr.gnt;
	assign pix_full = (count == cnt_w'(fifo_depth));

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			addr_mem[wr_ptr] <= pix_addr;
			data_mem[wr_ptr] <= pix_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + cnt_w'(push) - cnt_w'(pop); // push and pop may coincide
		end
	end

	// head entry sits on the bus until granted
	assign wr.req = (count != '0);
	assign wr.we = 1'b1;
	assign wr.addr = addr_mem[rd_ptr];
	assign wr.wdata = data_mem[rd_ptr];

	assert property (@(posedge clk) disable iff (!arst_n) wr.gnt |-> count != '0)
		else $error("pixel_loader: grant with empty FIFO");

endmodule

// File: source/udp_frame_builder.sv
`timescale 1ns/100ps

module udp_frame_builder
	import udp_tx_pkg::*;
#(
	parameter int payload_bytes = 1440,
	parameter int vram_addr_width = 16
) (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic advance,
	input logic [7:0] qos,
	input logic [15:0] segment_num,
	input logic [7:0] index_clone,
	input logic [15:0] aux,
	input logic [15:0] startaddr,
	output logic busy,
	output logic [7:0] data,
	output logic data_valid,
	output logic data_user,
	output logic data_enable,
	output logic [11:0] counter,
	vram_if.requester rd
);

	localparam logic [15:0] udp_len = 16'(udp_hdr_bytes + proto_bytes + payload_bytes);
	localparam logic [15:0] ip_len = 16'(ip_hdr_bytes) + udp_len;
	localparam logic [11:0] first_cnt = 12'(first_payload_count);
	localparam logic [11:0] last_cnt = 12'(first_payload_count + payload_bytes - 1);
	localparam logic [11:0] end_cnt = 12'(first_payload_count + payload_bytes + gap_count - 2);

	builder_state_e state;
	logic [7:0] qos_q;
	logic [15:0] segment_q;
	logic [7:0] index_q;
	logic [15:0] aux_q;
	logic [15:0] startaddr_q;
	logic [15:0] checksum_q;
	logic [31:0] sum_full;
	logic [16:0] sum_fold;
	logic [15:0] sum_ones;
	logic [11:0] next_cnt;
	logic [11:0] pay_idx;
	logic fetch;
	logic [7:0] byte_sel;

	assign busy = (state != st_idle);
	assign next_cnt = counter + 12'd1;

	// ip header sum, checksum field taken as zero
	always_comb begin
		sum_full = 32'({ip_ver_ihl, qos}) + 32'(ip_ident) + 32'(ip_len)
			+ 32'(ip_flags_df) + 32'({ip_ttl_val, ip_proto_udp})
			+ 32'(ip_src_addr[31:16]) + 32'(ip_src_addr[15:0])
			+ 32'(ip_dst_addr[31:16]) + 32'(ip_dst_addr[15:0]);
		sum_fold = 17'(sum_full[31:16]) + 17'(sum_full[15:0]);
		sum_ones = sum_fold[15:0] + 16'(sum_fold[16]); // end-around carry
	end

	// per-frame fields, captured once per frame
	always_ff @(posedge clk) begin
		if (start && !busy) begin
			qos_q <= qos;
			segment_q <= segment_num;
			index_q <= index_clone;
			aux_q <= aux;
			startaddr_q <= startaddr;
			checksum_q <= ~sum_ones;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			counter <= '0;
		end else if (state == st_idle) begin
			if (start) begin
				state <= st_header; // counter still 0, first advance gives byte 1
			end
		end else if (advance) begin
			case (state)
				st_header: begin
					counter <= next_cnt;
					if (next_cnt == first_cnt) begin
						state <= st_payload;
					end
				end
				st_payload: begin
					counter <= next_cnt;
					if (counter == last_cnt) begin
						state <= st_gap;
					end
				end
				default: begin // gap
					if (counter == end_cnt) begin
						counter <= '0;
						state <= st_idle;
					end else begin
						counter <= next_cnt;
					end
				end
			endcase
		end
	end

	// byte for the current count
	always_comb begin
		case (counter)
			12'd1: byte_sel = eth_dst_mac[47:40];
			12'd2: byte_sel = eth_dst_mac[39:32];
			12'd3: byte_sel = eth_dst_mac[31:24];
			12'd4: byte_sel = eth_dst_mac[23:16];
			12'd5: byte_sel = eth_dst_mac[15:8];
			12'd6: byte_sel = eth_dst_mac[7:0];
			12'd7: byte_sel = eth_src_mac[47:40];
			12'd8: byte_sel = eth_src_mac[39:32];
			12'd9: byte_sel = eth_src_mac[31:24];
			12'd10: byte_sel = eth_src_mac[23:16];
			12'd11: byte_sel = eth_src_mac[15:8];
			12'd12: byte_sel = eth_src_mac[7:0];
			12'd13: byte_sel = eth_type_ipv4[15:8];
			12'd14: byte_sel = eth_type_ipv4[7:0];
			12'd15: byte_sel = ip_ver_ihl;
			12'd16: byte_sel = qos_q; // dscp/ecn
			12'd17: byte_sel = ip_len[15:8];
			12'd18: byte_sel = ip_len[7:0];
			12'd19: byte_sel = ip_ident[15:8];
			12'd20: byte_sel = ip_ident[7:0];
			12'd21: byte_sel = ip_flags_df[15:8];
			12'd22: byte_sel = ip_flags_df[7:0];
			12'd23: byte_sel = ip_ttl_val;
			12'd24: byte_sel = ip_proto_udp;
			12'd25: byte_sel = checksum_q[15:8];
			12'd26: byte_sel = checksum_q[7:0];
			12'd27: byte_sel = ip_src_addr[31:24];
			12'd28: byte_sel = ip_src_addr[23:16];
			12'd29: byte_sel = ip_src_addr[15:8];
			12'd30: byte_sel = ip_src_addr[7:0];
			12'd31: byte_sel = ip_dst_addr[31:24];
			12'd32: byte_sel = ip_dst_addr[23:16];
			12'd33: byte_sel = ip_dst_addr[15:8];
			12'd34: byte_sel = ip_dst_addr[7:0];
			12'd35: byte_sel = segment_q[15:8]; // udp src port
			12'd36: byte_sel = segment_q[7:0];
			12'd37: byte_sel = index_q; // udp dst port hi
			12'd38: byte_sel = aux_q[15:8]; // udp dst port lo
			12'd39: byte_sel = udp_len[15:8];
			12'd40: byte_sel = udp_len[7:0];
			12'd41, 12'd42: byte_sel = 8'h00; // udp checksum not used
			12'd43: byte_sel = aux_q[7:0];
			12'd44: byte_sel = startaddr_q[15:8];
			12'd45: byte_sel = startaddr_q[7:0];
			default: begin
				byte_sel = (counter >= first_cnt && counter <= last_cnt) ? rd.rdata : 8'h00;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data <= '0;
			data_valid <= 1'b0;
			data_user <= 1'b0;
			data_enable <= 1'b0;
		end else begin
			data <= byte_sel; // flags registered alongside, so they line up with data
			data_valid <= (counter != '0) && (counter <= last_cnt);
			data_user <= (counter >= first_cnt) && (counter <= last_cnt);
			data_enable <= advance;
		end
	end

	// prefetch, rdata ready once the next count is current
	assign fetch = (state == st_header && counter == first_cnt - 12'd1)
		|| (state == st_payload && counter != last_cnt);
	assign pay_idx = next_cnt - first_cnt;
	assign rd.req = advance && fetch;
	assign rd.we = 1'b0;
	assign rd.wdata = '0;
	assign rd.addr = vram_addr_width'(startaddr_q) + vram_addr_width'(pay_idx);

	assert property (@(posedge clk) disable iff (!arst_n) rd.req |=> state == st_payload)
		else $error("udp_frame_builder: read not followed by payload");

	assert property (@(posedge clk) disable iff (!arst_n) counter <= end_cnt)
		else $error("udp_frame_builder: counter past end of gap");

	// fixed priority must never hold back a payload read
	assert property (@(posedge clk) disable iff (!arst_n) rd.req |-> rd.gnt)
		else $error("udp_frame_builder: payload read not granted");

endmodule

// File: source/udp_video_tx.sv
`timescale 1ns/100ps

module udp_video_tx #(
	parameter int payload_bytes = 1440,
	parameter int vram_addr_width = 16,
	parameter int fifo_depth = 4
) (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic advance,
	input logic [7:0] qos,
	input logic [15:0] segment_num,
	input logic [7:0] index_clone,
	input logic [15:0] aux,
	input logic [15:0] startaddr, // payload base in video ram
	input logic pix_wr,
	input logic [vram_addr_width-1:0] pix_addr,
	input logic [7:0] pix_data,
	output logic pix_full,
	output logic busy,
	output logic [7:0] data,
	output logic data_valid,
	output logic data_user,
	output logic data_enable,
	output logic [11:0] counter
);

	vram_if #(.vram_addr_width(vram_addr_width)) rd_bus ();
	vram_if #(.vram_addr_width(vram_addr_width)) wr_bus ();
	vram_if #(.vram_addr_width(vram_addr_width)) mem_bus ();

	pixel_loader #(
		.fifo_depth(fifo_depth),
		.vram_addr_width(vram_addr_width)
	) u_loader (
		.clk(clk),
		.arst_n(arst_n),
		.pix_wr(pix_wr),
		.pix_addr(pix_addr),
		.pix_data(pix_data),
		.pix_full(pix_full),
		.wr(wr_bus.requester)
	);

	udp_frame_builder #(
		.payload_bytes(payload_bytes),
		.vram_addr_width(vram_addr_width)
	) u_builder (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.advance(advance),
		.qos(qos),
		.segment_num(segment_num),
		.index_clone(index_clone),
		.aux(aux),
		.startaddr(startaddr),
		.busy(busy),
		.data(data),
		.data_valid(data_valid),
		.data_user(data_user),
		.data_enable(data_enable),
		.counter(counter),
		.rd(rd_bus.requester)
	);

	vram_arbiter u_arbiter (
		.clk(clk),
		.arst_n(arst_n),
		.rd(rd_bus.memory),
		.wr(wr_bus.memory),
		.mem(mem_bus.requester)
	);

	vram_store #(
		.vram_addr_width(vram_addr_width)
	) u_store (
		.clk(clk),
		.mem(mem_bus.memory)
	);

endmodule

// File: verif/frame_monitor.sv
`timescale 1ns/100ps

// rebuilds each frame from the top ports and checks it byte by byte
module frame_monitor
	import udp_tx_pkg::*;
#(
	parameter int payload_bytes = 32,
	parameter int vram_addr_width = 10
) (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic advance,
	input logic [7:0] qos,
	input logic [15:0] segment_num,
	input logic [7:0] index_clone,
	input logic [15:0] aux,
	input logic [15:0] startaddr,
	input logic pix_wr,
	input logic [vram_addr_width-1:0] pix_addr,
	input logic [7:0] pix_data,
	input logic pix_full,
	input logic busy,
	input logic [7:0] data,
	input logic data_valid,
	input logic data_user,
	input logic data_enable,
	input logic [11:0] counter
);

	localparam int last_count = first_payload_count + payload_bytes - 1;
	localparam int frame_advances = last_count + gap_count; // header, payload, gap
	localparam logic [15:0] udp_len = 16'(udp_hdr_bytes + proto_bytes + payload_bytes);
	localparam logic [15:0] ip_len = 16'(ip_hdr_bytes) + udp_len;

	logic [7:0] shadow [2 ** vram_addr_width]; // what the ram should hold
	logic [7:0] f_qos;
	logic [15:0] f_seg;
	logic [7:0] f_idx;
	logic [15:0] f_aux;
	logic [15:0] f_sa;
	logic [7:0] exp_data;
	logic exp_valid;
	logic exp_user;
	logic adv_q;
	logic ref_busy; // frame in flight, from start and the advance count
	int ref_cnt; // expected counter value
	int cnt_q;
	int errors = 0;

	// one's-complement sum of the ten ip header words, checksum word as zero
	function automatic logic [15:0] ip_checksum(input logic [7:0] tos);
		logic [159:0] hdr;
		logic [31:0] sum;
		int i;
		hdr = {ip_ver_ihl, tos, ip_len, ip_ident, ip_flags_df, ip_ttl_val, ip_proto_udp,
			16'h0000, ip_src_addr, ip_dst_addr};
		sum = 0;
		for (i = 0; i < 10; i++) begin
			sum = sum + 32'(hdr[159 - 16 * i -: 16]);
		end
		while (sum[31:16] != 0) begin
			sum = 32'(sum[15:0]) + 32'(sum[31:16]); // fold the carries back in
		end
		return ~sum[15:0];
	endfunction

	// frame byte n, counted from 1
	function automatic logic [7:0] expected_byte(input int n);
		logic [359:0] hdr;
		hdr = {eth_dst_mac, eth_src_mac, eth_type_ipv4,
			ip_ver_ihl, f_qos, ip_len, ip_ident, ip_flags_df, ip_ttl_val, ip_proto_udp,
			ip_checksum(f_qos), ip_src_addr, ip_dst_addr,
			f_seg, f_idx, f_aux[15:8], udp_len, 16'h0000, // udp checksum sent as zero
			f_aux[7:0], f_sa};
		if (n == 0 || n > last_count) begin
			return 8'h00;
		end
		if (n >= first_payload_count) begin
			return shadow[vram_addr_width'(f_sa + 16'(n - first_payload_count))];
		end
		return hdr[359 - 8 * (n - 1) -: 8];
	endfunction

	// accepted pixel writes and the fields of a real start
	always_ff @(posedge clk) begin
		if (arst_n && pix_wr && !pix_full) begin
			shadow[pix_addr] <= pix_data;
		end
		if (arst_n && start && !ref_busy) begin
			f_qos <= qos;
			f_seg <= segment_num;
			f_idx <= index_clone;
			f_aux <= aux;
			f_sa <= startaddr;
		end
	end

	// expected outputs, one cycle behind the count like the data register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exp_data <= '0;
			exp_valid <= 1'b0;
			exp_user <= 1'b0;
			adv_q <= 1'b0;
			ref_busy <= 1'b0;
			ref_cnt <= 0;
			cnt_q <= 0;
		end else begin
			exp_data <= expected_byte(ref_cnt);
			exp_valid <= (ref_cnt != 0) && (ref_cnt <= last_count);
			exp_user <= (ref_cnt >= first_payload_count) && (ref_cnt <= last_count);
			adv_q <= advance;
			cnt_q <= ref_cnt;
			if (!ref_busy) begin
				ref_busy <= start; // start while busy is ignored
			end else if (advance) begin
				if (ref_cnt == frame_advances - 1) begin
					ref_busy <= 1'b0; // last gap advance, back to idle
					ref_cnt <= 0;
				end else begin
					ref_cnt <= ref_cnt + 1;
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) exp_valid |-> data == exp_data)
		else begin
			errors++;
			$display("FAIL data_byte_%0d: expected %h, actual %h",
				$sampled(cnt_q), $sampled(exp_data), $sampled(data));
		end

	assert property (@(posedge clk) disable iff (!arst_n)
		data_valid == exp_valid && data_user == exp_user)
		else begin
			errors++;
			$display("FAIL flags_at_count_%0d: expected valid,user %b%b, actual %b%b",
				$sampled(cnt_q), $sampled(exp_valid), $sampled(exp_user),
				$sampled(data_valid), $sampled(data_user));
		end

	assert property (@(posedge clk) disable iff (!arst_n) data_enable == adv_q)
		else begin
			errors++;
			$display("FAIL data_enable: expected %b, actual %b",
				$sampled(adv_q), $sampled(data_enable));
		end

	// rises after start, falls after the last gap advance
	assert property (@(posedge clk) disable iff (!arst_n) busy == ref_busy)
		else begin
			errors++;
			$display("FAIL busy: expected %b, actual %b", $sampled(ref_busy), $sampled(busy));
		end

	// holds through stalls, back to 0 after the gap
	assert property (@(posedge clk) disable iff (!arst_n) counter == 12'(ref_cnt))
		else begin
			errors++;
			$display("FAIL counter: expected %0d, actual %0d",
				$sampled(ref_cnt), $sampled(counter));
		end

endmodule

// File: verif/tb_udp_video_tx.sv
`timescale 1ns/100ps

module tb_udp_video_tx
	import udp_tx_pkg::*;
();

	localparam int payload_bytes = 32;
	localparam int vram_addr_width = 10;
	localparam int burst_writes = 80; // long enough to outlast the payload reads
	localparam int frame_cycles = first_payload_count + payload_bytes + gap_count;
	localparam int cycle_limit = 6 * frame_cycles * 3 + 3 * (2 * payload_bytes + burst_writes) + 200;
	localparam logic [15:0] base_a = 16'h0040;
	localparam logic [15:0] base_b = 16'h0230; // no overlap with base_a

	logic clk;
	logic arst_n;
	logic start;
	logic advance;
	logic [7:0] qos;
	logic [15:0] segment_num;
	logic [7:0] index_clone;
	logic [15:0] aux;
	logic [15:0] startaddr;
	logic pix_wr;
	logic [vram_addr_width-1:0] pix_addr;
	logic [7:0] pix_data;
	logic pix_full;
	logic busy;
	logic [7:0] data;
	logic data_valid;
	logic data_user;
	logic data_enable;
	logic [11:0] counter;
	int errors = 0;
	int err_mark = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int dropped;
	int cycles;
	int seed = 32'h69f7_5fc2;

	udp_video_tx #(
		.payload_bytes(payload_bytes),
		.vram_addr_width(vram_addr_width),
		.fifo_depth(4)
	) UUT (.*);

	frame_monitor #(
		.payload_bytes(payload_bytes),
		.vram_addr_width(vram_addr_width)
	) mon (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({busy, data, data_valid, data_user, data_enable, pix_full, counter}))
		else begin
			errors++;
			$display("top level outputs went unknown after reset");
		end

	// inputs change 1 ns after the edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// fill one payload region, dropped writes are sent again
	task automatic load_region(input logic [15:0] base);
		int i;
		i = 0;
		while (i < payload_bytes) begin
			pix_wr = 1'b1;
			pix_addr = vram_addr_width'(base + 16'(i));
			pix_data = 8'($urandom);
			if (!pix_full) begin
				i++;
			end
			step();
		end
		pix_wr = 1'b0;
	endtask

	// one write per cycle into a region, no retry
	task automatic write_burst(input logic [15:0] base, input int n);
		repeat (n) begin
			pix_wr = 1'b1;
			pix_addr = vram_addr_width'(base + 16'($urandom % payload_bytes));
			pix_data = 8'($urandom);
			if (pix_full) begin
				dropped++;
			end
			step();
		end
		pix_wr = 1'b0;
	endtask

	task automatic run_frame(input logic random_adv, input logic restart);
		int n;
		qos = 8'($urandom);
		segment_num = 16'($urandom);
		index_clone = 8'($urandom);
		aux = 16'($urandom);
		start = 1'b1;
		step();
		start = 1'b0;
		n = 0;
		while (busy) begin
			qos = 8'($urandom); // latched copies must not follow these
			segment_num = 16'($urandom);
			index_clone = 8'($urandom);
			aux = 16'($urandom);
			startaddr = 16'($urandom);
			advance = random_adv ? 1'($urandom) : 1'b1;
			start = restart && (n % 16 == 5);
			n++;
			step();
		end
		advance = 1'b0;
		start = 1'b0;
	endtask

	task automatic finish_test(input string name);
		int n;
		n = errors + mon.errors - err_mark;
		err_mark = errors + mon.errors;
		tests_run++;
		if (n == 0) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d checks failed", name, n);
		end
	endtask

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still going after %0d cycles", cycle_limit);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		void'($urandom(seed));
		arst_n = 1'b0;
		start = 1'b0;
		advance = 1'b0;
		qos = '0;
		segment_num = '0;
		index_clone = '0;
		aux = '0;
		startaddr = '0;
		pix_wr = 1'b0;
		pix_addr = '0;
		pix_data = '0;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		assert (!busy && !data_valid && !data_user && !data_enable && !pix_full && counter == 0)
			else begin
				errors++;
				$display("reset_state: outputs not idle after reset");
			end
		finish_test("reset_state");

		step();
		load_region(base_a);
		load_region(base_b);
		startaddr = base_a;
		run_frame(1'b0, 1'b0);
		finish_test("header_stream");

		startaddr = base_b;
		run_frame(1'b0, 1'b0);
		finish_test("payload_stream");

		startaddr = base_a;
		run_frame(1'b1, 1'b0);
		finish_test("random_advance");

		// loader starved by payload reads, then base_a read back
		dropped = 0;
		startaddr = base_b;
		fork
			run_frame(1'b0, 1'b0);
			write_burst(base_a, burst_writes);
		join
		assert (dropped > 0)
			else begin
				errors++;
				$display("writes_during_frame: pix_full never rose while the frame streamed");
			end
		startaddr = base_a;
		run_frame(1'b1, 1'b0);
		finish_test("writes_during_frame");

		startaddr = base_b;
		run_frame(1'b0, 1'b1);
		finish_test("start_while_busy");

		$display("tests run %0d, tests failed %0d, check failures %0d",
			tests_run, tests_failed, errors + mon.errors);
		if (tests_failed == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: tb.f
common/udp_tx_pkg.sv
common/vram_if.sv
vram/vram_store.sv
vram/vram_arbiter.sv
source/pixel_loader.sv
source/udp_frame_builder.sv
source/udp_video_tx.sv
verif/frame_monitor.sv
verif/tb_udp_video_tx.sv

// File: Bender.yml
package:
  name: udp_video_tx

sources:
  - files:
      - common/udp_tx_pkg.sv
      - common/vram_if.sv
      - vram/vram_store.sv
      - vram/vram_arbiter.sv
      - source/pixel_loader.sv
      - source/udp_frame_builder.sv
      - source/udp_video_tx.sv
  - target: test
    files:
      - verif/frame_monitor.sv
      - verif/tb_udp_video_tx.sv
